// File: project.f
hdl/adc_pkg.sv
hdl/runup_sequencer.sv
hdl/record_fifo.sv
hdl/result_reporter.sv
hdl/adc_top.sv
tests/adc_props.sv
tests/tb_adc.sv

// File: run.sh
#!/bin/sh
# build and run the ADC run-up testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_adc -o sim_tb_adc

output=$(./obj_dir/sim_tb_adc)
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi

// File: tests/tb_adc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc
  import adc_pkg::*;
();

  localparam int HALF_PERIOD = 20;
  localparam int N_TESTS = 5;
  localparam int T_ENRST = 0;
  localparam int T_BAL = 1;
  localparam int T_RAND = 2;
  localparam int T_RAIL = 3;
  localparam int T_BP = 4;
  // one conversion takes a bit more than this
  localparam int CONV_CYCLES = PERIOD_CYCLES * RUNUP_PERIODS;
  // switches open this long means the sequencer is stuck offering
  localparam int STALL_CYCLES = 10 * PERIOD_CYCLES;

  logic clk;
  logic arst_n;
  logic enable;
  logic cmp_out;
  logic rd_ack;
  sw_ctl_t sw;
  logic cmp_latch;
  reading_t rd;
  logic rd_req;

  // comparator model state
  int mode;
  int conv_mode;
  int lat_idx;
  int conv_cnt;
  // clocks since the run-up was first seen
  int conv_cyc;
  logic sig_prev;
  // samples shift in at the top, first sample ends at bit 0
  logic [RUNUP_PERIODS-1:0] samples;
  reading_t exp_rd;
  count_rec_t exp_cnt;
  // expected readings, their counts and the test each belongs to
  reading_t exp_q[$];
  count_rec_t cnt_q[$];
  int tag_q[$];
  int started [N_TESTS];
  int checked [N_TESTS];
  int failed [N_TESTS];
  string names [N_TESTS];
  int stray_cnt;
  int ack_wait;
  bit hold_ack;
  bit timed_out;

  adc_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .cmp_out   (cmp_out),
    .sw        (sw),
    .cmp_latch (cmp_latch),
    .rd        (rd),
    .rd_req    (rd_req),
    .rd_ack    (rd_ack)
  );

  bind runup_sequencer adc_props props_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sw        (sw),
    .cmp_latch (cmp_latch),
    .rec_req   (rec_req),
    .rec_ack   (rec_ack)
  );

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // polarity rule: period 0 positive, then negative after a high sample
  function automatic reading_t expected_reading(input logic [RUNUP_PERIODS-1:0] smp,
                                                input int conv, output count_rec_t counts);
    reading_t r;
    logic [RUNUP_PERIODS-1:0] s;
    int pos;
    int neg;
    pos = 1;
    neg = 0;
    s = smp;
    // the last sample of a conversion steers nothing
    for (int k = 1; k < RUNUP_PERIODS; k++)
    begin
      if (s[0])
        neg++;
      else
        pos++;
      s = s >> 1;
    end
    counts.count_pos = CNT_W'(pos);
    counts.count_neg = CNT_W'(neg);
    counts.seq = SEQ_W'(conv);
    r.value = (CNT_W + 1)'(pos - neg);
    r.overload = (pos == RUNUP_PERIODS) || (neg == RUNUP_PERIODS);
    r.seq = SEQ_W'(conv);
    return r;
  endfunction

  // comparator level for period i of a conversion in test t
  function automatic logic pick_cmp(input int t, input int i);
    if (t == T_BAL)
      return (i % 2) == 0;
    else if (t == T_RAIL)
      return 1'b0;
    else
      return 1'($urandom_range(1, 0));
  endfunction

  // comparator model, follows the switch and latch outputs
  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      sig_prev = 1'b0;
      lat_idx = 0;
      conv_cyc = 0;
    end
    else
    begin
      conv_cyc++;
      // first clock of a run-up seen, its test is fixed here
      if (sw.sig_sw && !sig_prev)
      begin
        conv_mode = mode;
        lat_idx = 0;
        conv_cyc = 0;
        started[conv_mode]++;
        cmp_out <= pick_cmp(conv_mode, 0);
      end
      sig_prev = sw.sig_sw;
      if (cmp_latch)
      begin
        // strobe sits on the last clock of period lat_idx
        assert (conv_cyc == (lat_idx + 1) * PERIOD_CYCLES - 1)
        else
        begin
          $display("FAILED %s expected cmp_latch at clock %0d actual clock %0d",
                   names[conv_mode], (lat_idx + 1) * PERIOD_CYCLES - 1, conv_cyc);
          failed[conv_mode]++;
        end
        // level the DUT samples on this very edge
        samples = {cmp_out, samples[RUNUP_PERIODS-1:1]};
        lat_idx++;
        if (lat_idx == RUNUP_PERIODS)
        begin
          exp_rd = expected_reading(samples, conv_cnt, exp_cnt);
          exp_q.push_back(exp_rd);
          cnt_q.push_back(exp_cnt);
          tag_q.push_back(conv_mode);
          conv_cnt++;
        end
        else
        begin
          cmp_out <= pick_cmp(conv_mode, lat_idx);
        end
      end
    end
  end

  task automatic check_reading();
    reading_t e;
    count_rec_t c;
    int t;
    string exp_s;
    if (exp_q.size() == 0)
    begin
      $display("a reading arrived with no finished conversion behind it");
      stray_cnt++;
    end
    else
    begin
      e = exp_q.pop_front();
      c = cnt_q.pop_front();
      t = tag_q.pop_front();
      checked[t]++;
      assert (rd === e)
      else
      begin
        exp_s = $sformatf("value=%0d overload=%0b seq=%0d (pos=%0d neg=%0d)", e.value,
                          e.overload, e.seq, c.count_pos, c.count_neg);
        $display("FAILED %s expected %s actual value=%0d overload=%0b seq=%0d",
                 names[t], exp_s, rd.value, rd.overload, rd.seq);
        failed[t]++;
      end
    end
  endtask

  // four-phase sink on rd with a random ack delay
  always @(posedge clk)
  begin
    if (rd_req && !rd_ack && !hold_ack)
    begin
      if (ack_wait > 0)
      begin
        ack_wait--;
      end
      else
      begin
        check_reading();
        rd_ack <= 1'b1;
      end
    end
    else if (!rd_req && rd_ack)
    begin
      rd_ack <= 1'b0;
      ack_wait = $urandom_range(6, 0);
    end
  end

  task automatic check_idle_after_reset();
    int cyc;
    @(posedge clk);
    assert (sw == '0 && rd_req === 1'b0)
    else
    begin
      $display("switches or rd_req active right after reset");
      failed[T_ENRST]++;
    end
    checked[T_ENRST]++;
    // with enable low this loop is meant to run out
    cyc = 0;
    while (rd_req !== 1'b1 && sw == '0 && cyc < 2 * CONV_CYCLES)
    begin
      @(posedge clk);
      cyc++;
    end
    assert (rd_req !== 1'b1 && sw == '0)
    else
    begin
      $display("activity seen with enable low");
      failed[T_ENRST]++;
    end
    checked[T_ENRST]++;
    $display("test %s: %0d checks, %0d failed", names[T_ENRST], checked[T_ENRST],
             failed[T_ENRST]);
  endtask

  // switch the stimulus to test t and wait for n of its conversions to start
  task automatic begin_test(input int t, input int n);
    int cyc;
    cyc = 0;
    if (!timed_out)
    begin
      @(posedge clk);
      mode <= t;
      enable <= 1'b1;
      while (started[t] < n && cyc < (n + 2) * CONV_CYCLES)
      begin
        @(posedge clk);
        cyc++;
      end
      if (started[t] < n)
      begin
        $display("timeout: test %s did not start %0d conversions", names[t], n);
        timed_out = 1'b1;
      end
    end
  endtask

  // wait until every reading of test t is checked, then report it
  task automatic finish_test(input int t);
    int cyc;
    cyc = 0;
    if (!timed_out)
    begin
      while (checked[t] < started[t] && cyc < 4 * CONV_CYCLES)
      begin
        @(posedge clk);
        cyc++;
      end
      if (checked[t] < started[t])
      begin
        $display("timeout: test %s got %0d of %0d readings", names[t], checked[t], started[t]);
        timed_out = 1'b1;
      end
      else
      begin
        $display("test %s: %0d readings, %0d failed", names[t], checked[t], failed[t]);
      end
    end
  endtask

  task automatic stall_fifo();
    int cyc;
    int off_run;
    begin_test(T_BP, 1);
    finish_test(T_RAIL);
    if (!timed_out)
    begin
      @(posedge clk);
      hold_ack <= 1'b1;
      cyc = 0;
      off_run = 0;
      while (off_run < STALL_CYCLES && cyc < (FIFO_DEPTH + 4) * CONV_CYCLES)
      begin
        @(posedge clk);
        cyc++;
        off_run = (sw == '0) ? off_run + 1 : 0;
      end
      if (off_run < STALL_CYCLES)
      begin
        $display("timeout: sequencer never stalled with rd_ack withheld");
        timed_out = 1'b1;
      end
      else
      begin
        // integrator must stay idle for as long as the stall lasts
        for (int i = 0; i < CONV_CYCLES; i++)
        begin
          @(posedge clk);
          assert (sw == '0)
          else
          begin
            $display("switches closed while the sequencer was stalled");
            failed[T_BP]++;
          end
        end
        assert (started[T_BP] >= FIFO_DEPTH)
        else
        begin
          $display("stall came after only %0d conversions", started[T_BP]);
          failed[T_BP]++;
        end
        hold_ack <= 1'b0;
      end
    end
  endtask

  initial
  begin
    int total_checks;
    int total_fail;
    void'($urandom(32'h7b87_cb34));
    arst_n = 1'b0;
    enable = 1'b0;
    cmp_out = 1'b0;
    rd_ack = 1'b0;
    mode = T_BAL;
    conv_cnt = 0;
    stray_cnt = 0;
    ack_wait = 0;
    hold_ack = 1'b0;
    timed_out = 1'b0;
    names = '{"enable_reset", "balanced", "random", "railed", "back_pressure"};
    for (int i = 0; i < N_TESTS; i++)
    begin
      started[i] = 0;
      checked[i] = 0;
      failed[i] = 0;
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    check_idle_after_reset();
    begin_test(T_BAL, 2);
    begin_test(T_RAND, 6);
    finish_test(T_BAL);
    begin_test(T_RAIL, 1);
    finish_test(T_RAND);
    stall_fifo();
    if (!timed_out)
    begin
      @(posedge clk);
      enable <= 1'b0;
    end
    finish_test(T_BP);

    total_checks = 0;
    total_fail = stray_cnt;
    for (int i = 0; i < N_TESTS; i++)
    begin
      total_checks += checked[i];
      total_fail += failed[i];
    end
    $display("tests %0d, checks %0d, failures %0d, unchecked readings %0d", N_TESTS,
             total_checks, total_fail, exp_q.size());
    if (!timed_out && total_fail == 0 && exp_q.size() == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/adc_props.sv
`timescale 1ns/1ps
`default_nettype none

module adc_props
  import adc_pkg::*;
(
  input logic    clk,
  input logic    arst_n,
  input sw_ctl_t sw,
  input logic    cmp_latch,
  input logic    rec_req,
  input logic    rec_ack
);

  // both references on at once would short them through the integrator
  ref_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(sw.pos_sw && sw.neg_sw))
    else $error("pos_sw and neg_sw are on together");

  // a reference only goes in alongside the unknown input
  sig_with_ref: assert property (@(posedge clk) disable iff (!arst_n)
    (sw.pos_sw || sw.neg_sw) |-> sw.sig_sw)
    else $error("reference switch on without sig_sw");

  // comparator latch strobe lasts one clock
  latch_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    cmp_latch |=> !cmp_latch)
    else $error("cmp_latch held high for more than one clock");

  // record request holds until the FIFO answers
  req_holds: assert property (@(posedge clk) disable iff (!arst_n)
    (rec_req && !rec_ack) |=> rec_req)
    else $error("rec_req dropped before rec_ack rose");

endmodule

`default_nettype wire

// File: hdl/adc_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_top
  import adc_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     enable,
  input  logic     cmp_out,
  output sw_ctl_t  sw,
  output logic     cmp_latch,
  output reading_t rd,
  output logic     rd_req,
  input  logic     rd_ack
);

  // sequencer to FIFO
  count_rec_t rec;
  logic rec_req;
  logic rec_ack;

  // FIFO to reporter
  count_rec_t out_rec;
  logic fifo_req;
  logic fifo_ack;

  runup_sequencer seq_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .cmp_out   (cmp_out),
    .sw        (sw),
    .cmp_latch (cmp_latch),
    .rec       (rec),
    .rec_req   (rec_req),
    .rec_ack   (rec_ack)
  );

  record_fifo fifo_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_rec  (rec),
    .in_req  (rec_req),
    .in_ack  (rec_ack),
    .out_rec (out_rec),
    .out_req (fifo_req),
    .out_ack (fifo_ack)
  );

  result_reporter rep_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rec     (out_rec),
    .rec_req (fifo_req),
    .rec_ack (fifo_ack),
    .rd      (rd),
    .rd_req  (rd_req),
    .rd_ack  (rd_ack)
  );

endmodule

`default_nettype wire

// File: hdl/result_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module result_reporter
  import adc_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  count_rec_t rec,
  input  logic       rec_req,
  output logic       rec_ack,
  output reading_t   rd,
  output logic       rd_req,
  input  logic       rd_ack
);

  logic rec_ack_q;
  logic rd_req_q;
  // a reading sits here until the outside has taken it
  logic holding;
  reading_t rd_q;
  logic accept;

  // new record taken only with both links back at rest
  assign accept = rec_req && !rec_ack_q && !holding && !rd_ack;

  assign rec_ack = rec_ack_q;
  assign rd_req = rd_req_q;
  assign rd = rd_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rec_ack_q <= 1'b0;
      rd_req_q <= 1'b0;
      holding <= 1'b0;
      rd_q <= '0;
    end
    else
    begin
      // input link from the FIFO
      if (accept)
      begin
        // positive periods minus negative periods, one extra bit for the sign
        rd_q.value <= $signed({1'b0, rec.count_pos}) - $signed({1'b0, rec.count_neg});
        // one reference for the whole run-up means the integrator railed
        rd_q.overload <= (rec.count_pos == CNT_RAIL) || (rec.count_neg == CNT_RAIL);
        rd_q.seq <= rec.seq;
        rec_ack_q <= 1'b1;
        holding <= 1'b1;
      end
      else if (rec_ack_q && !rec_req)
      begin
        rec_ack_q <= 1'b0;
      end

      // output link, req goes up one clock after the record is taken
      if (rd_req_q && rd_ack)
      begin
        rd_req_q <= 1'b0;
        holding <= 1'b0;
      end
      else if (holding && !rd_req_q)
      begin
        rd_req_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/record_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module record_fifo
  import adc_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  count_rec_t in_rec,
  input  logic       in_req,
  output logic       in_ack,
  output count_rec_t out_rec,
  output logic       out_req,
  input  logic       out_ack
);

  count_rec_t mem [FIFO_DEPTH];
  // pointers wrap on their own, depth is a power of two
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] level;
  logic in_ack_q;
  logic out_req_q;
  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full = (level == FIFO_FULL);
  assign empty = (level == '0);

  // new request seen with ack low and room left
  assign push = in_req && !in_ack_q && !full;
  // consumer took the head entry
  assign pop = out_req_q && out_ack;

  assign in_ack = in_ack_q;
  assign out_req = out_req_q;
  // head entry is not overwritten while it is still stored
  assign out_rec = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_rec;
    end
  end

  // write side handshake
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      in_ack_q <= 1'b0;
      wr_ptr <= '0;
    end
    else if (push)
    begin
      in_ack_q <= 1'b1;
      wr_ptr <= wr_ptr + 1'b1;
    end
    else if (in_ack_q && !in_req)
    begin
      in_ack_q <= 1'b0;
    end
  end

  // read side handshake
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_req_q <= 1'b0;
      rd_ptr <= '0;
    end
    else if (pop)
    begin
      out_req_q <= 1'b0;
      rd_ptr <= rd_ptr + 1'b1;
    end
    else if (!out_req_q && !out_ack && !empty)
    begin
      // previous ack must be gone before the next offer
      out_req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      level <= '0;
    end
    else
    begin
      case ({push, pop})
        2'b10: level <= level + 1'b1;
        2'b01: level <= level - 1'b1;
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/runup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module runup_sequencer
  import adc_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       enable,
  input  logic       cmp_out,
  output sw_ctl_t    sw,
  output logic       cmp_latch,
  output count_rec_t rec,
  output logic       rec_req,
  input  logic       rec_ack
);

  logic [1:0] state;
  // two-flop synchroniser for the asynchronous comparator
  logic cmp_meta;
  logic cmp_sync;
  logic [TIMER_W-1:0] timer;
  logic [IDX_W-1:0] period_idx;
  logic [CNT_W-1:0] count_pos;
  logic [CNT_W-1:0] count_neg;
  logic [SEQ_W-1:0] seq;
  // switch register also holds the polarity decision for the running period
  sw_ctl_t sw_q;
  logic latch_q;
  logic rec_req_q;
  logic rel_done;
  logic start;

  // record handshake finished once ack is back low
  assign rel_done = (state == SEQ_RELEASE) && !rec_ack;
  // a new run-up may start from idle or straight out of the release phase
  assign start = enable && ((state == SEQ_IDLE) || rel_done);

  assign sw = sw_q;
  assign cmp_latch = latch_q;
  assign rec_req = rec_req_q;
  // counts stay frozen while the record is offered
  assign rec = '{count_pos: count_pos, count_neg: count_neg, seq: seq};

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cmp_meta <= 1'b0;
      cmp_sync <= 1'b0;
    end
    else
    begin
      cmp_meta <= cmp_out;
      cmp_sync <= cmp_meta;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= SEQ_IDLE;
      timer <= '0;
      period_idx <= '0;
      count_pos <= '0;
      count_neg <= '0;
      seq <= '0;
      sw_q <= '0;
      latch_q <= 1'b0;
      rec_req_q <= 1'b0;
    end
    else
    begin
      // latch pulse lands on the last clock of every period
      latch_q <= (state == SEQ_RUNUP) && (timer == TIMER_PRE);

      if (rel_done)
      begin
        seq <= seq + 1'b1;
      end

      if (start)
      begin
        state <= SEQ_RUNUP;
        timer <= '0;
        period_idx <= '0;
        count_pos <= '0;
        count_neg <= '0;
        // first period is always positive
        sw_q <= '{sig_sw: 1'b1, pos_sw: 1'b1, neg_sw: 1'b0};
      end
      else
      begin
        case (state)
          SEQ_RUNUP:
          begin
            timer <= timer + 1'b1;
            if (timer == TIMER_LAST)
            begin
              timer <= '0;
              // count the reference used in the period just ending
              if (sw_q.pos_sw)
              begin
                count_pos <= count_pos + 1'b1;
              end
              else
              begin
                count_neg <= count_neg + 1'b1;
              end
              if (period_idx == IDX_LAST)
              begin
                // run-up over, integrator left floating
                state <= SEQ_OFFER;
                sw_q <= '0;
              end
              else
              begin
                period_idx <= period_idx + 1'b1;
                // comparator high means integrator went positive, pull it back
                sw_q <= '{sig_sw: 1'b1, pos_sw: !cmp_sync, neg_sw: cmp_sync};
              end
            end
          end
          SEQ_OFFER:
          begin
            // req goes up one clock after the switches open
            if (!rec_req_q)
            begin
              rec_req_q <= 1'b1;
            end
            else if (rec_ack)
            begin
              rec_req_q <= 1'b0;
              state <= SEQ_RELEASE;
            end
          end
          SEQ_RELEASE:
          begin
            // enable low here, so park
            if (rel_done)
            begin
              state <= SEQ_IDLE;
            end
          end
          default:
          begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/adc_pkg.sv
`default_nettype none

package adc_pkg;

  // run-up geometry
  localparam int PERIOD_CYCLES = 40;
  localparam int RUNUP_PERIODS = 64;
  localparam int CNT_W = 8;
  localparam int SEQ_W = 8;
  localparam int FIFO_DEPTH = 4;

  // derived widths
  localparam int TIMER_W = $clog2(PERIOD_CYCLES);
  localparam int IDX_W = $clog2(RUNUP_PERIODS);
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // timer value of the last clock in a period, and the one before it
  localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(PERIOD_CYCLES - 1);
  localparam logic [TIMER_W-1:0] TIMER_PRE = TIMER_W'(PERIOD_CYCLES - 2);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(RUNUP_PERIODS - 1);
  // a count at this value means one reference for the whole run-up
  localparam logic [CNT_W-1:0] CNT_RAIL = CNT_W'(RUNUP_PERIODS);
  localparam logic [PTR_W:0] FIFO_FULL = (PTR_W + 1)'(FIFO_DEPTH);

  // sequencer control states
  localparam logic [1:0] SEQ_IDLE = 2'd0;
  localparam logic [1:0] SEQ_RUNUP = 2'd1;
  localparam logic [1:0] SEQ_OFFER = 2'd2;
  localparam logic [1:0] SEQ_RELEASE = 2'd3;

  typedef struct packed {
    logic [CNT_W-1:0] count_pos;
    logic [CNT_W-1:0] count_neg;
    logic [SEQ_W-1:0] seq;
  } count_rec_t;

  typedef struct packed {
    logic signed [CNT_W:0] value;
    logic overload;
    logic [SEQ_W-1:0] seq;
  } reading_t;

  // integrator switch controls
  typedef struct packed {
    logic sig_sw;
    logic pos_sw;
    logic neg_sw;
  } sw_ctl_t;

endpackage

`default_nettype wire
